//--- src/arch_pkg.sv
`default_nettype none

package arch_pkg;

  // data word width
  localparam int XLEN = 32;

  // architectural register file
  localparam int NUM_REGS  = 32;
  localparam int REG_IDX_W = 5;

  // producer tags; value 0 is reserved for "ready"
  localparam int TAG_W    = 4;
  localparam int NUM_TAGS = 16;

  // register index
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // producer tag of an in-flight result
  typedef logic [TAG_W-1:0] tag_t;

  // data word
  typedef logic [XLEN-1:0] word_t;

  // no pending producer
  localparam tag_t TAG_READY = tag_t'(0);

endpackage

`default_nettype wire

//--- src/bus_pkg.sv
`default_nettype none

package bus_pkg;

  import arch_pkg::*;

  // instruction at the issue stage
  typedef struct packed {
    // request present this cycle
    logic     valid;
    // destination, 0 means no write-back
    reg_idx_t rd;
    // source operands
    reg_idx_t rs1;
    reg_idx_t rs2;
  } issue_req_t;

  // destination rename, from the tag pool into the status file
  typedef struct packed {
    // asserted when a destination is renamed this cycle
    logic     write;
    reg_idx_t rd;
    // freshly granted tag
    tag_t     tag;
  } rename_t;

  // common data bus broadcast
  typedef struct packed {
    logic     active;
    // tag of the finishing result
    tag_t     tag;
    // destination register of that result
    reg_idx_t rd;
    word_t    val;
  } cdb_t;

  // one source operand
  typedef struct packed {
    // tag to wait for, or TAG_READY
    tag_t  q;
    // value, only meaningful when q is TAG_READY
    word_t v;
  } operand_t;

endpackage

`default_nettype wire

//--- src/operand_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module operand_bypass
  import arch_pkg::*, bus_pkg::*;
(
  input  wire cdb_t     cdb,
  input  wire operand_t raw,
  output operand_t      fwd
);

  logic hit;

  // operand waits on exactly the tag being broadcast now
  assign hit = cdb.active && (raw.q != TAG_READY) && (raw.q == cdb.tag);

  always_comb begin
    if (hit) begin
      // take the result straight off the bus
      fwd.q = TAG_READY;
      fwd.v = cdb.val;
    end else begin
      fwd = raw;
    end
  end

endmodule

`default_nettype wire

//--- src/reg_status_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_status_file
  import arch_pkg::*, bus_pkg::*;
(
  input  wire logic       clk_in,
  input  wire logic       rst_in,
  input  wire logic       rdy_in,
  input  wire logic       flush,
  // only the source indices and valid are used here
  input  wire issue_req_t issue,
  input  wire rename_t    rename,
  input  wire cdb_t       cdb,
  output operand_t        rd1,
  output operand_t        rd2
);

  // architectural values
  word_t value_q [NUM_REGS];
  // producer tag per register
  tag_t  tag_q   [NUM_REGS];

  // one combinational read port
  // value is only handed out once the register is ready
  function automatic operand_t read_port(input logic en, input reg_idx_t idx);
    operand_t op;
    op.q = en ? tag_q[idx] : TAG_READY;
    op.v = (en && op.q == TAG_READY) ? value_q[idx] : '0;
    return op;
  endfunction

  // same-cycle reads
  always_comb begin
    rd1 = read_port(issue.valid, issue.rs1);
    rd2 = read_port(issue.valid, issue.rs2);
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      // everything ready and zero
      for (int i = 0; i < NUM_REGS; i++) begin
        value_q[i] <= '0;
        tag_q[i]   <= TAG_READY;
      end
    end else if (rdy_in) begin
      if (flush) begin
        // mispredict, drop all pending producers
        // values already written stay
        for (int i = 0; i < NUM_REGS; i++) begin
          tag_q[i] <= TAG_READY;
        end
      end else begin
        // result write-back
        // x0 is hardwired, never touched
        if (cdb.active && cdb.rd != '0) begin
          value_q[cdb.rd] <= cdb.val;
          // only clear if this broadcast is still the latest producer
          if (tag_q[cdb.rd] == cdb.tag) begin
            tag_q[cdb.rd] <= TAG_READY;
          end
        end
        // rename comes last so it wins over a clear on the same register
        if (rename.write && rename.rd != '0) begin
          tag_q[rename.rd] <= rename.tag;
        end
      end
    end
    // rdy_in low: hold everything
  end

endmodule

`default_nettype wire

//--- src/tag_pool.sv
`timescale 1ns/1ps
`default_nettype none

module tag_pool
  import arch_pkg::*, bus_pkg::*;
(
  input  wire logic       clk_in,
  input  wire logic       rst_in,
  input  wire logic       rdy_in,
  input  wire logic       flush,
  input  wire issue_req_t issue,
  input  wire cdb_t       cdb,
  output rename_t         rename,
  output tag_t            issue_tag,
  output logic            issue_stall
);

  // bit t set means tag t is free; tag 0 is never allocated
  logic [NUM_TAGS-1:1] free_q;
  logic [NUM_TAGS-1:1] free_next;

  logic need_tag;
  logic any_free;
  logic grant;
  tag_t pick;

  // destination wants a tag, x0 never does
  assign need_tag = issue.valid && (issue.rd != '0);
  assign any_free = |free_q;

  // lowest free tag
  // scan downward so the lowest set bit is the last one written
  always_comb begin
    pick = TAG_READY;
    for (int t = NUM_TAGS - 1; t >= 1; t--) begin
      if (free_q[t]) begin
        pick = tag_t'(t);
      end
    end
  end

  // no grant while paused or flushing
  assign grant = need_tag && any_free && rdy_in && !flush;

  assign issue_tag   = grant ? pick : TAG_READY;
  assign issue_stall = need_tag && !any_free;

  // tell the status file which register gets renamed
  assign rename.write = grant;
  assign rename.rd    = issue.rd;
  assign rename.tag   = pick;

  always_comb begin
    free_next = free_q;
    // broadcast returns its tag
    if (cdb.active && cdb.tag != TAG_READY) begin
      free_next[cdb.tag] = 1'b1;
    end
    // grant applied last, keeps the tag allocated
    if (grant) begin
      free_next[pick] = 1'b0;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      free_q <= '1;
    end else if (rdy_in) begin
      // flush releases the whole pool
      free_q <= flush ? '1 : free_next;
    end
  end

endmodule

`default_nettype wire

//--- src/rename_core.sv
`timescale 1ns/1ps
`default_nettype none

module rename_core
  import arch_pkg::*, bus_pkg::*;
(
  input  wire logic       clk_in,
  input  wire logic       rst_in,
  input  wire logic       rdy_in,
  // mispredict
  input  wire logic       flush,
  input  wire issue_req_t issue,
  input  wire cdb_t       cdb,
  output operand_t        src1,
  output operand_t        src2,
  output tag_t            issue_tag,
  output logic            issue_stall
);

  rename_t  rename;
  // operands before forwarding
  operand_t rd1;
  operand_t rd2;

  // allocator, decides when a destination is renamed
  tag_pool u_pool (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .rdy_in      (rdy_in),
    .flush       (flush),
    .issue       (issue),
    .cdb         (cdb),
    .rename      (rename),
    .issue_tag   (issue_tag),
    .issue_stall (issue_stall)
  );

  reg_status_file u_rsf (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .rdy_in (rdy_in),
    .flush  (flush),
    .issue  (issue),
    .rename (rename),
    .cdb    (cdb),
    .rd1    (rd1),
    .rd2    (rd2)
  );

  // same-cycle CDB forwarding per source
  operand_bypass u_byp1 (
    .cdb (cdb),
    .raw (rd1),
    .fwd (src1)
  );

  operand_bypass u_byp2 (
    .cdb (cdb),
    .raw (rd2),
    .fwd (src2)
  );

endmodule

`default_nettype wire

//--- bench/rename_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module rename_core_assert
  import arch_pkg::*, bus_pkg::*;
(
  input wire logic     clk_in,
  input wire logic     rst_in,
  input wire logic     rdy_in,
  input wire operand_t src1,
  input wire operand_t src2,
  input wire tag_t     issue_tag,
  input wire logic     issue_stall
);

  // failure count, summed into the closing line
  int unsigned fails = 0;

  // a stalled issue never carries a tag
  stall_no_tag: assert property (
    @(posedge clk_in) disable iff (rst_in) !(issue_stall && issue_tag != TAG_READY)
  ) else begin
    fails++;
    $error("issue_stall high together with tag %0d", issue_tag);
  end

  // paused core grants nothing
  paused_no_tag: assert property (
    @(posedge clk_in) disable iff (rst_in) !rdy_in |-> issue_tag == TAG_READY
  ) else begin
    fails++;
    $error("tag %0d granted while rdy_in low", issue_tag);
  end

  // sources come out ready right after reset
  reset_ready: assert property (
    @(posedge clk_in) rst_in |=> (src1.q == TAG_READY && src2.q == TAG_READY)
  ) else begin
    fails++;
    $error("source tag pending after reset");
  end

endmodule

bind rename_core rename_core_assert u_assert (
  .clk_in      (clk_in),
  .rst_in      (rst_in),
  .rdy_in      (rdy_in),
  .src1        (src1),
  .src2        (src2),
  .issue_tag   (issue_tag),
  .issue_stall (issue_stall)
);

`default_nettype wire

//--- bench/rename_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rename_core_tb
  import arch_pkg::*, bus_pkg::*;
();

  logic       clk_in;
  logic       rst_in;
  logic       rdy_in;
  logic       flush;
  issue_req_t issue;
  cdb_t       cdb;
  operand_t   src1;
  operand_t   src2;
  tag_t       issue_tag;
  logic       issue_stall;

  // step table with one entry per cycle
  string      t_name[$];
  issue_req_t t_issue[$];
  cdb_t       t_cdb[$];
  logic       t_flush[$];
  logic       t_rdy[$];
  operand_t   t_src1[$];
  operand_t   t_src2[$];
  tag_t       t_tag[$];
  logic       t_stall[$];
  // expected columns come from the reference model
  logic       t_rnd[$];

  // reference model state
  word_t               m_val [NUM_REGS];
  tag_t                m_tag [NUM_REGS];
  logic [NUM_TAGS-1:1] m_free;

  int errors = 0;
  int assert_errors = 0;
  int cycles = 0;
  int cycle_limit = 1000;
  int seed = 9;

  rename_core u_dut (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .rdy_in      (rdy_in),
    .flush       (flush),
    .issue       (issue),
    .cdb         (cdb),
    .src1        (src1),
    .src2        (src2),
    .issue_tag   (issue_tag),
    .issue_stall (issue_stall)
  );

  always #2 clk_in = ~clk_in;

  // run limit
  always @(posedge clk_in) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  function automatic operand_t operand(input tag_t q, input word_t v);
    return {q, v};
  endfunction

  function automatic issue_req_t request(input reg_idx_t rd, input reg_idx_t rs1,
                                         input reg_idx_t rs2);
    return {1'b1, rd, rs1, rs2};
  endfunction

  function automatic cdb_t broadcast(input tag_t tag, input reg_idx_t rd, input word_t val);
    return {1'b1, tag, rd, val};
  endfunction

  task automatic add_row(input string name, input issue_req_t is, input cdb_t c,
                         input logic fl, input logic rdy, input operand_t e1,
                         input operand_t e2, input tag_t et, input logic es,
                         input logic rnd = 1'b0);
    t_name.push_back(name);
    t_issue.push_back(is);
    t_cdb.push_back(c);
    t_flush.push_back(fl);
    t_rdy.push_back(rdy);
    t_src1.push_back(e1);
    t_src2.push_back(e2);
    t_tag.push_back(et);
    t_stall.push_back(es);
    t_rnd.push_back(rnd);
  endtask

  // model read port followed by bus forwarding
  function automatic operand_t ref_read(input issue_req_t is, input reg_idx_t idx,
                                        input cdb_t c);
    operand_t o;
    o = '0;
    if (is.valid) begin
      o.q = m_tag[idx];
      if (o.q == TAG_READY) o.v = m_val[idx];
    end
    if (c.active && o.q != TAG_READY && o.q == c.tag) o = {TAG_READY, c.val};
    return o;
  endfunction

  // outputs of row i and then the state after its edge
  task automatic predict_row(input int i);
    issue_req_t is;
    cdb_t       c;
    tag_t       pick;
    logic       need;
    logic       grant;
    is = t_issue[i];
    c = t_cdb[i];
    pick = TAG_READY;
    // lowest free tag
    for (int t = 1; t < NUM_TAGS; t++) begin
      if (m_free[t] && pick == TAG_READY) pick = tag_t'(t);
    end
    need = is.valid && is.rd != '0;
    grant = need && pick != TAG_READY && t_rdy[i] && !t_flush[i];
    if (t_rnd[i]) begin
      t_src1[i] = ref_read(is, is.rs1, c);
      t_src2[i] = ref_read(is, is.rs2, c);
      t_tag[i] = grant ? pick : TAG_READY;
      t_stall[i] = need && pick == TAG_READY;
    end
    if (t_rdy[i] && t_flush[i]) begin
      foreach (m_tag[r]) m_tag[r] = TAG_READY;
      m_free = '1;
    end else if (t_rdy[i]) begin
      if (c.active && c.rd != '0) begin
        m_val[c.rd] = c.val;
        if (m_tag[c.rd] == c.tag) m_tag[c.rd] = TAG_READY;
      end
      if (c.active && c.tag != TAG_READY) m_free[c.tag] = 1'b1;
      // rename after the clear
      if (grant) begin
        m_tag[is.rd] = pick;
        m_free[pick] = 1'b0;
      end
    end
  endtask

  task automatic fill_expected();
    foreach (m_val[r]) begin
      m_val[r] = '0;
      m_tag[r] = TAG_READY;
    end
    m_free = '1;
    for (int i = 0; i < t_name.size(); i++) predict_row(i);
  endtask

  task automatic build_table();
    issue_req_t is;
    cdb_t       c;
    // reset state with x0 never renamed or written
    add_row("reset_read", request(0, 3, 31), '0, 0, 1, '0, '0, TAG_READY, 0);
    add_row("x0_bcast", '0, broadcast(3, 0, 32'hdead_beef), 0, 1, '0, '0, TAG_READY, 0);
    add_row("x0_read", request(0, 0, 0), '0, 0, 1, '0, '0, TAG_READY, 0);
    // rename and clear
    add_row("rename_r5", request(5, 1, 2), '0, 0, 1, '0, '0, tag_t'(1), 0);
    add_row("read_r5", request(0, 5, 0), '0, 0, 1, operand(1, 0), '0, TAG_READY, 0);
    add_row("bcast_t1", '0, broadcast(1, 5, 32'h1111_0005), 0, 1, '0, '0, TAG_READY, 0);
    add_row("ready_r5", request(0, 5, 5), '0, 0, 1, operand(0, 32'h1111_0005),
            operand(0, 32'h1111_0005), TAG_READY, 0);
    // stale broadcast keeps the newer tag
    add_row("rename_r6_a", request(6, 0, 0), '0, 0, 1, '0, '0, tag_t'(1), 0);
    add_row("rename_r6_b", request(6, 6, 0), '0, 0, 1, operand(1, 0), '0, tag_t'(2), 0);
    add_row("stale_bcast", '0, broadcast(1, 6, 32'h2222_0006), 0, 1, '0, '0, TAG_READY, 0);
    add_row("stale_read", request(0, 6, 0), '0, 0, 1, operand(2, 0), '0, TAG_READY, 0);
    // same-cycle forwarding
    add_row("bypass", request(0, 6, 6), broadcast(2, 6, 32'h3333_0006), 0, 1,
            operand(0, 32'h3333_0006), operand(0, 32'h3333_0006), TAG_READY, 0);
    add_row("after_bypass", request(0, 6, 0), '0, 0, 1, operand(0, 32'h3333_0006), '0,
            TAG_READY, 0);
    // r8..r22 take tags 1..15
    for (int k = 0; k < 15; k++) begin
      is = request(reg_idx_t'(8 + k), reg_idx_t'($random(seed)), reg_idx_t'($random(seed)));
      add_row($sformatf("fill_%0d", k), is, '0, 0, 1, '0, '0, TAG_READY, 0, 1);
    end
    add_row("pool_empty", request(23, 0, 0), '0, 0, 1, '0, '0, TAG_READY, 1);
    add_row("free_t4", '0, broadcast(4, 11, 32'h4444_000b), 0, 1, '0, '0, TAG_READY, 0);
    add_row("regrant_t4", request(23, 11, 8), '0, 0, 1, operand(0, 32'h4444_000b),
            operand(1, 0), tag_t'(4), 0);
    // mispredict
    add_row("flush", '0, '0, 1, 1, '0, '0, TAG_READY, 0);
    add_row("post_flush", request(24, 5, 11), '0, 0, 1, operand(0, 32'h1111_0005),
            operand(0, 32'h4444_000b), tag_t'(1), 0);
    // paused core where only the bypass reacts
    add_row("rdy_low_before", request(0, 24, 6), '0, 0, 1, operand(1, 0),
            operand(0, 32'h3333_0006), TAG_READY, 0);
    add_row("rdy_low", request(25, 24, 6), broadcast(1, 24, 32'h5555_0018), 0, 0,
            operand(0, 32'h5555_0018), operand(0, 32'h3333_0006), TAG_READY, 0);
    // tag 1 still held by r24, so the pool hands out tag 2
    add_row("rdy_low_after", request(26, 24, 6), '0, 0, 1, operand(1, 0),
            operand(0, 32'h3333_0006), tag_t'(2), 0);
    // random traffic
    for (int k = 0; k < 10; k++) begin
      is = issue_req_t'($random(seed));
      c = {1'b1, tag_t'($random(seed)), reg_idx_t'($random(seed)), word_t'($random(seed))};
      c.active = $random(seed);
      add_row($sformatf("random_%0d", k), is, c, 0, ($random(seed) & 3) != 0, '0, '0,
              TAG_READY, 0, 1);
    end
  endtask

  task automatic check_operand(input string name, input string what, input operand_t exp,
                               input operand_t act);
    if (act !== exp) begin
      errors++;
      $display("FAILED %s %s: expected q=%0d v=%h, actual q=%0d v=%h",
               name, what, exp.q, exp.v, act.q, act.v);
    end
  endtask

  task automatic check_tag(input string name, input tag_t exp, input tag_t act);
    if (act !== exp) begin
      errors++;
      $display("FAILED %s issue_tag: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("FAILED %s issue_stall: expected %b, actual %b", name, exp, act);
    end
  endtask

  initial begin
    clk_in = 1'b0;
    rst_in = 1'b1;
    rdy_in = 1'b1;
    flush = 1'b0;
    // a read held through reset shows the cleared tags
    issue = request(0, 7, 31);
    cdb = '0;
    build_table();
    fill_expected();
    cycle_limit = t_name.size() + 20;
    repeat (4) @(posedge clk_in);
    #1;
    rst_in = 1'b0;
    for (int i = 0; i < t_name.size(); i++) begin
      @(posedge clk_in);
      #1;
      issue = t_issue[i];
      cdb = t_cdb[i];
      flush = t_flush[i];
      rdy_in = t_rdy[i];
      // settle before the next edge
      #2;
      check_operand(t_name[i], "src1", t_src1[i], src1);
      check_operand(t_name[i], "src2", t_src2[i], src2);
      check_tag(t_name[i], t_tag[i], issue_tag);
      check_bit(t_name[i], t_stall[i], issue_stall);
    end
    @(posedge clk_in);
    #1;
    issue = '0;
    cdb = '0;
    flush = 1'b0;
    rdy_in = 1'b1;
    @(posedge clk_in);
    assert_errors = u_dut.u_assert.fails;
    $display("summary: %0d value mismatches, %0d assertion failures", errors, assert_errors);
    if (errors == 0 && assert_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
src/arch_pkg.sv
src/bus_pkg.sv
src/operand_bypass.sv
src/reg_status_file.sv
src/tag_pool.sv
src/rename_core.sv
bench/rename_core_assert.sv
bench/rename_core_tb.sv

//--- Bender.yml
package:
  name: rename_core

sources:
  # design
  - files:
      - src/arch_pkg.sv
      - src/bus_pkg.sv
      - src/operand_bypass.sv
      - src/reg_status_file.sv
      - src/tag_pool.sv
      - src/rename_core.sv

  # testbench and bound assertions
  - target: test
    files:
      - bench/rename_core_assert.sv
      - bench/rename_core_tb.sv
